// ==== Makefile ====
TOP = mem_pipe_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f -o $(TOP)

run: compile
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir

// ==== bench/mem_pipe_properties.sv ====
`timescale 1ns/100ps
`include "mem_pipe_macros.svh"

module mem_pipe_properties import mem_pipe_pkg::*; (
    input logic      clk,
    input logic      reset,
    input logic      in_allowin,
    input logic      es_to_ms_valid,
    input es_to_ms_t es_to_ms_bus,
    input logic      ms_to_ws_valid,
    input ms_to_ws_t ms_to_ws_bus,
    input logic      ws_allowin,
    input byte_en_t  ram_we
);

    // pipeline empty right after reset
    assert property (@(posedge clk)
        reset |=> (!es_to_ms_valid && !ms_to_ws_valid && in_allowin))
        else $error("valid outputs not cleared by reset");

    // stalled write-back record must not move
    assert property (@(posedge clk) disable iff (reset)
        (ms_to_ws_valid && !ws_allowin) |=> (ms_to_ws_valid && $stable(ms_to_ws_bus)))
        else $error("write-back record changed while stalled");

    // lane writes only for good stores
    assert property (@(posedge clk) disable iff (reset)
        (ram_we != 4'b0000) |-> (!es_to_ms_bus.ex &&
            (es_to_ms_bus.op == `MEM_OP_SB || es_to_ms_bus.op == `MEM_OP_SH ||
             es_to_ms_bus.op == `MEM_OP_SW)))
        else $error("RAM write enabled for a faulting or non-store access");

endmodule

bind mem_pipe_top mem_pipe_properties mem_pipe_props (.*);

// ==== bench/mem_pipe_tb.sv ====
`timescale 1ns/100ps
`include "mem_pipe_macros.svh"

module mem_pipe_tb import mem_pipe_pkg::*; ();

    localparam int N_RANDOM       = 2000;
    localparam int N_WORDS        = 16;  // 64-byte window
    localparam int TIMEOUT_CYCLES = 4 * (N_RANDOM + 16) + 200;

    logic      clk = 1'b0;
    logic      reset;
    logic      in_valid;
    mem_req_t  in_req;
    logic      in_allowin;
    logic      ws_allowin;
    logic      ms_to_ws_valid;
    ms_to_ws_t ms_to_ws_bus;

    logic [31:0] rng_state = 32'd67;
    word_t       ref_mem [0:N_WORDS-1];  // model of the window
    ms_to_ws_t   exp_q[$];
    string       name_q[$];
    int          n_in = 0;
    int          cycle_count = 0;

    mem_pipe_top mem_pipe_top_inst (
        .clk            (clk),
        .reset          (reset),
        .in_valid       (in_valid),
        .in_req         (in_req),
        .in_allowin     (in_allowin),
        .ws_allowin     (ws_allowin),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_to_ws_bus   (ms_to_ws_bus)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] rand_next();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic word_t fill_word(input logic [3:0] wi);
        return ({28'd0, wi} + 32'd1) * 32'h9E37_79B9;
    endfunction

    function automatic string op_name(input mem_op_t op);
        case (op)
            `MEM_OP_ALU: return "alu";
            `MEM_OP_LB:  return "lb";
            `MEM_OP_LBU: return "lbu";
            `MEM_OP_LH:  return "lh";
            `MEM_OP_LHU: return "lhu";
            `MEM_OP_LW:  return "lw";
            `MEM_OP_LWL: return "lwl";
            `MEM_OP_LWR: return "lwr";
            `MEM_OP_SB:  return "sb";
            `MEM_OP_SH:  return "sh";
            `MEM_OP_SW:  return "sw";
            default:     return "unknown";
        endcase
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            fail_now($sformatf("MISMATCH %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            fail_now($sformatf("MISMATCH %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_now($sformatf("MISMATCH %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // expected write-back record with memory updated in program order
    task automatic model_accept(input mem_req_t r);
        word_t      sum;
        word_t      w;
        word_t      res;
        ram_addr_t  a;
        logic [3:0] idx;
        logic [7:0] b;
        logic [15:0] h;
        logic       fault;
        int         n;
        ms_to_ws_t  e;
        sum   = r.base + r.offset;
        a     = sum[`RAM_ADDR_WD-1:0];
        idx   = a[5:2];
        n     = int'(a[1:0]);
        w     = ref_mem[idx];
        b     = w[8*n +: 8];
        h     = w[8*(n & 2) +: 16];
        fault = 1'b0;
        case (r.op)
            `MEM_OP_LW, `MEM_OP_SW:              fault = (n != 0);
            `MEM_OP_LH, `MEM_OP_LHU, `MEM_OP_SH: fault = a[0];
            default: ;
        endcase
        e.gr_we = !fault;
        e.dest  = r.dest;
        e.ex    = fault;
        res     = sum;
        if (fault) begin
            res = word_t'(a);  // low address bits only
        end else begin
            case (r.op)
                `MEM_OP_LB:  res = {{24{b[7]}}, b};
                `MEM_OP_LBU: res = {24'd0, b};
                `MEM_OP_LH:  res = {{16{h[15]}}, h};
                `MEM_OP_LHU: res = {16'd0, h};
                `MEM_OP_LW:  res = w;
                `MEM_OP_LWL: begin
                    for (int k = 0; k < 4; k++) begin
                        if (k >= 3 - n) res[8*k +: 8] = w[8*(k-3+n) +: 8];
                        else            res[8*k +: 8] = r.rt_value[8*k +: 8];
                    end
                end
                `MEM_OP_LWR: begin
                    for (int k = 0; k < 4; k++) begin
                        if (k <= 3 - n) res[8*k +: 8] = w[8*(k+n) +: 8];
                        else            res[8*k +: 8] = r.rt_value[8*k +: 8];
                    end
                end
                `MEM_OP_SB, `MEM_OP_SH, `MEM_OP_SW: begin
                    e.gr_we = 1'b0;
                    res     = r.rt_value;
                    if (r.op == `MEM_OP_SB)      ref_mem[idx][8*n +: 8]  = r.rt_value[7:0];
                    else if (r.op == `MEM_OP_SH) ref_mem[idx][8*n +: 16] = r.rt_value[15:0];
                    else                         ref_mem[idx] = r.rt_value;
                end
                default: ;
            endcase
        end
        e.result = res;
        exp_q.push_back(e);
        name_q.push_back($sformatf("%s #%0d", op_name(r.op), n_in));
        n_in++;
    endtask

    task automatic check_output();
        ms_to_ws_t e;
        string     name;
        if (ms_to_ws_valid && ws_allowin) begin
            if (exp_q.size() == 0) begin
                fail_now("output transfer seen with no instruction outstanding");
            end else begin
                e    = exp_q.pop_front();
                name = name_q.pop_front();
                check_flag({name, " ex"}, e.ex, ms_to_ws_bus.ex);
                check_flag({name, " gr_we"}, e.gr_we, ms_to_ws_bus.gr_we);
                check_reg({name, " dest"}, e.dest, ms_to_ws_bus.dest);
                check_word({name, " result"}, e.result, ms_to_ws_bus.result);
            end
        end
    endtask

    // drive at the falling edge and look once things settle
    task automatic drive_cycle(input logic valid, input mem_req_t req, output logic accepted);
        logic [31:0] r;
        @(negedge clk);
        r          = rand_next();
        in_valid   = valid;
        in_req     = req;
        ws_allowin = (r[1:0] != 2'b00);  // about 75% ready
        #1;
        check_output();
        accepted = valid && in_allowin;
        if (accepted) model_accept(req);
    endtask

    task automatic send_req(input mem_req_t req);
        logic        accepted;
        logic [31:0] r;
        r = rand_next();
        while (r[1:0] == 2'b00) begin  // idle gap
            drive_cycle(1'b0, '0, accepted);
            r = rand_next();
        end
        accepted = 1'b0;
        while (!accepted) begin
            drive_cycle(1'b1, req, accepted);  // held until taken
        end
    endtask

    task automatic make_random_req(output mem_req_t r);
        logic [31:0] pick;
        logic [31:0] upper;
        logic [5:0]  waddr;
        word_t       target;
        pick  = rand_next();
        upper = rand_next();
        r.op  = pick[3:0] % 4'd11;
        waddr = pick[9:4];
        if (pick[11:10] != 2'b00) begin  // mostly aligned
            if (r.op == `MEM_OP_LW || r.op == `MEM_OP_SW) waddr[1:0] = 2'b00;
            if (r.op == `MEM_OP_LH || r.op == `MEM_OP_LHU || r.op == `MEM_OP_SH) waddr[0] = 1'b0;
        end
        target     = {upper[31:10], 4'd0, waddr};  // upper bits land outside the RAM
        r.base     = rand_next();
        r.offset   = (r.op == `MEM_OP_ALU) ? rand_next() : target - r.base;
        r.rt_value = rand_next();
        r.dest     = pick[16:12];
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_now("timeout: outputs did not drain within the cycle limit");
        end
    end

    initial begin
        mem_req_t    req;
        logic        accepted;
        logic [31:0] upper;
        in_valid   = 1'b0;
        in_req     = '0;
        ws_allowin = 1'b0;
        reset      = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // known contents in every window word
        for (int i = 0; i < N_WORDS; i++) begin
            upper        = rand_next();
            req.op       = `MEM_OP_SW;
            req.base     = rand_next();
            req.offset   = {upper[31:10], 4'd0, i[3:0], 2'b00} - req.base;
            req.rt_value = fill_word(i[3:0]);
            req.dest     = i[4:0];
            send_req(req);
        end

        for (int i = 0; i < N_RANDOM; i++) begin
            make_random_req(req);
            send_req(req);
        end

        while (exp_q.size() != 0) begin
            drive_cycle(1'b0, '0, accepted);
        end

        // nothing more may come out once the last record is gone
        repeat (4) begin
            drive_cycle(1'b0, '0, accepted);
        end

        if (!ms_to_ws_valid) begin
            $display("Everything OK");
            $finish;
        end else begin
            fail_now("pipeline still holds a record after the last expected one");
        end
    end

endmodule

// ==== compile.f ====
+incdir+hdl
hdl/mem_pipe_pkg.sv
hdl/agu_stage.sv
hdl/data_ram.sv
hdl/mem_stage.sv
hdl/mem_pipe_top.sv
bench/mem_pipe_properties.sv
bench/mem_pipe_tb.sv

// ==== hdl/agu_stage.sv ====
`timescale 1ns/100ps
`include "mem_pipe_macros.svh"

module agu_stage import mem_pipe_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    // from upstream
    input  logic      in_valid,
    input  mem_req_t  in_req,
    output logic      in_allowin,
    // to memory stage
    input  logic      ms_allowin,
    output logic      es_to_ms_valid,
    output es_to_ms_t es_to_ms_bus,
    // data RAM port
    output logic      ram_en,
    output byte_en_t  ram_we,
    output ram_addr_t ram_addr,
    output word_t     ram_wdata
);

    logic     es_valid;
    mem_req_t es_req;
    logic     es_fire;
    word_t    sum;
    logic     misaligned;
    byte_en_t store_be;
    word_t    store_data;

    // ready_go is always 1 here, no multi-cycle work
    assign es_fire        = es_valid && ms_allowin;
    assign in_allowin     = !es_valid || ms_allowin;
    assign es_to_ms_valid = es_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (in_allowin) begin
            es_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            es_req <= in_req;
        end
    end

    assign sum = es_req.base + es_req.offset;

    // alignment check per access size
    always_comb begin
        case (es_req.op)
            `MEM_OP_LW, `MEM_OP_SW:              misaligned = (sum[1:0] != 2'b00);
            `MEM_OP_LH, `MEM_OP_LHU, `MEM_OP_SH: misaligned = sum[0];
            default:                             misaligned = 1'b0;
        endcase
    end

    // lane enables and replicated store data
    always_comb begin
        store_be   = 4'b0000;  // loads and alu never write
        store_data = es_req.rt_value;
        case (es_req.op)
            `MEM_OP_SB: begin
                store_be   = 4'b0001 << sum[1:0];
                store_data = {4{es_req.rt_value[7:0]}};
            end
            `MEM_OP_SH: begin
                store_be   = sum[1] ? 4'b1100 : 4'b0011;
                store_data = {2{es_req.rt_value[15:0]}};
            end
            `MEM_OP_SW: begin
                store_be = 4'b1111;
            end
            default: ;
        endcase
    end

    // one RAM access, at the edge the record moves on
    assign ram_en    = es_fire;
    assign ram_we    = (es_fire && !misaligned) ? store_be : 4'b0000;
    assign ram_addr  = sum[`RAM_ADDR_WD-1:0];
    assign ram_wdata = store_data;

    assign es_to_ms_bus = '{
        op:       es_req.op,
        addr:     sum,
        rt_value: es_req.rt_value,
        dest:     es_req.dest,
        ex:       misaligned
    };

endmodule

// ==== hdl/data_ram.sv ====
`timescale 1ns/100ps
`include "mem_pipe_macros.svh"

module data_ram import mem_pipe_pkg::*; (
    input  logic      clk,
    input  logic      ram_en,
    input  byte_en_t  ram_we,
    input  ram_addr_t ram_addr,
    input  word_t     ram_wdata,
    output word_t     ram_rdata
);

    localparam int WORDS = 2 ** (`RAM_ADDR_WD - 2);

    word_t                   mem [0:WORDS-1];
    logic [`RAM_ADDR_WD-3:0] word_idx;

    assign word_idx = ram_addr[`RAM_ADDR_WD-1:2];

    // read-first: rdata takes the old word even when a lane is written
    always_ff @(posedge clk) begin
        if (ram_en) begin
            for (int i = 0; i < 4; i++) begin
                if (ram_we[i]) begin
                    mem[word_idx][8*i +: 8] <= ram_wdata[8*i +: 8];
                end
            end
            ram_rdata <= mem[word_idx];  // holds until the next access
        end
    end

endmodule

// ==== hdl/mem_pipe_macros.svh ====
`ifndef MEM_PIPE_MACROS_SVH
`define MEM_PIPE_MACROS_SVH

`define DATA_WD     32
`define RAM_ADDR_WD 10  // byte address, 256 words
`define REG_ADDR_WD 5
`define MEM_OP_WD   4

// operation codes carried in mem_op_t
`define MEM_OP_ALU  4'd0
`define MEM_OP_LB   4'd1
`define MEM_OP_LBU  4'd2
`define MEM_OP_LH   4'd3
`define MEM_OP_LHU  4'd4
`define MEM_OP_LW   4'd5
`define MEM_OP_LWL  4'd6
`define MEM_OP_LWR  4'd7
`define MEM_OP_SB   4'd8
`define MEM_OP_SH   4'd9
`define MEM_OP_SW   4'd10

`endif

// ==== hdl/mem_pipe_pkg.sv ====
`include "mem_pipe_macros.svh"

package mem_pipe_pkg;

    typedef logic [`DATA_WD-1:0]     word_t;
    typedef logic [`RAM_ADDR_WD-1:0] ram_addr_t;  // bits 1:0 pick the lane
    typedef logic [`REG_ADDR_WD-1:0] reg_addr_t;
    typedef logic [`MEM_OP_WD-1:0]   mem_op_t;
    typedef logic [3:0]              byte_en_t;   // one bit per byte lane

    // request from the upstream stage
    typedef struct packed {
        mem_op_t   op;
        word_t     base;
        word_t     offset;
        word_t     rt_value;  // store data, or old value for lwl/lwr
        reg_addr_t dest;
    } mem_req_t;

    // execute to memory
    typedef struct packed {
        mem_op_t   op;
        word_t     addr;      // full base + offset
        word_t     rt_value;
        reg_addr_t dest;
        logic      ex;        // address error
    } es_to_ms_t;

    // memory to write-back
    typedef struct packed {
        logic      gr_we;
        reg_addr_t dest;
        word_t     result;
        logic      ex;
    } ms_to_ws_t;

endpackage

// ==== hdl/mem_pipe_top.sv ====
`timescale 1ns/100ps

module mem_pipe_top import mem_pipe_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    // request side
    input  logic      in_valid,
    input  mem_req_t  in_req,
    output logic      in_allowin,
    // write-back side
    input  logic      ws_allowin,
    output logic      ms_to_ws_valid,
    output ms_to_ws_t ms_to_ws_bus
);

    logic      es_to_ms_valid;
    es_to_ms_t es_to_ms_bus;
    logic      ms_allowin;

    logic      ram_en;
    byte_en_t  ram_we;
    ram_addr_t ram_addr;
    word_t     ram_wdata;
    word_t     ram_rdata;

    agu_stage u_agu (
        .clk            (clk),
        .reset          (reset),
        .in_valid       (in_valid),
        .in_req         (in_req),
        .in_allowin     (in_allowin),
        .ms_allowin     (ms_allowin),
        .es_to_ms_valid (es_to_ms_valid),
        .es_to_ms_bus   (es_to_ms_bus),
        .ram_en         (ram_en),
        .ram_we         (ram_we),
        .ram_addr       (ram_addr),
        .ram_wdata      (ram_wdata)
    );

    data_ram u_ram (
        .clk       (clk),
        .ram_en    (ram_en),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

    mem_stage u_mem (
        .clk            (clk),
        .reset          (reset),
        .es_to_ms_valid (es_to_ms_valid),
        .es_to_ms_bus   (es_to_ms_bus),
        .ms_allowin     (ms_allowin),
        .ram_rdata      (ram_rdata),
        .ws_allowin     (ws_allowin),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_to_ws_bus   (ms_to_ws_bus)
    );

endmodule

// ==== hdl/mem_stage.sv ====
`timescale 1ns/100ps
`include "mem_pipe_macros.svh"

module mem_stage import mem_pipe_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    // from execute stage
    input  logic      es_to_ms_valid,
    input  es_to_ms_t es_to_ms_bus,
    output logic      ms_allowin,
    // from data RAM
    input  word_t     ram_rdata,
    // to write-back
    input  logic      ws_allowin,
    output logic      ms_to_ws_valid,
    output ms_to_ws_t ms_to_ws_bus
);

    logic        ms_valid;
    es_to_ms_t   ms_rec;
    logic [1:0]  lane;
    logic [7:0]  lb_byte;
    logic [15:0] lh_half;
    word_t       lwl_data;
    word_t       lwr_data;
    word_t       final_result;
    logic        gr_we;

    assign ms_allowin     = !ms_valid || ws_allowin;
    assign ms_to_ws_valid = ms_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es_to_ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_to_ms_valid && ms_allowin) begin
            ms_rec <= es_to_ms_bus;
        end
    end

    assign lane    = ms_rec.addr[1:0];
    assign lb_byte = ram_rdata[{lane, 3'b000} +: 8];  // little-endian lanes
    assign lh_half = lane[1] ? ram_rdata[31:16] : ram_rdata[15:0];

    // unaligned word merge with the old register value
    always_comb begin
        case (lane)
            2'd0: begin
                lwl_data = {ram_rdata[7:0], ms_rec.rt_value[23:0]};
                lwr_data = ram_rdata;
            end
            2'd1: begin
                lwl_data = {ram_rdata[15:0], ms_rec.rt_value[15:0]};
                lwr_data = {ms_rec.rt_value[31:24], ram_rdata[31:8]};
            end
            2'd2: begin
                lwl_data = {ram_rdata[23:0], ms_rec.rt_value[7:0]};
                lwr_data = {ms_rec.rt_value[31:16], ram_rdata[31:16]};
            end
            default: begin
                lwl_data = ram_rdata;
                lwr_data = {ms_rec.rt_value[31:8], ram_rdata[31:24]};
            end
        endcase
    end

    always_comb begin
        gr_we        = 1'b1;
        final_result = ms_rec.addr;  // alu result
        if (ms_rec.ex) begin
            // faulting address goes out instead of data
            gr_we        = 1'b0;
            final_result = {{(`DATA_WD-`RAM_ADDR_WD){1'b0}}, ms_rec.addr[`RAM_ADDR_WD-1:0]};
        end else begin
            case (ms_rec.op)
                `MEM_OP_LB:  final_result = {{24{lb_byte[7]}}, lb_byte};
                `MEM_OP_LBU: final_result = {24'd0, lb_byte};
                `MEM_OP_LH:  final_result = {{16{lh_half[15]}}, lh_half};
                `MEM_OP_LHU: final_result = {16'd0, lh_half};
                `MEM_OP_LW:  final_result = ram_rdata;
                `MEM_OP_LWL: final_result = lwl_data;
                `MEM_OP_LWR: final_result = lwr_data;
                `MEM_OP_SB, `MEM_OP_SH, `MEM_OP_SW: begin
                    gr_we        = 1'b0;
                    final_result = ms_rec.rt_value;
                end
                default: ;
            endcase
        end
    end

    assign ms_to_ws_bus = '{
        gr_we:  gr_we,
        dest:   ms_rec.dest,
        result: final_result,
        ex:     ms_rec.ex
    };

endmodule
